//--- list.f
rtl/flash_pkg.sv
rtl/qspi_phy.sv
rtl/flash_sequencer.sv
rtl/flash_controller.sv
test/flash_model.sv
test/tb_flash_controller.sv

//--- run.sh
#!/bin/bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_flash_controller \
    -f list.f -o tb_flash_controller &&
./obj_dir/tb_flash_controller | tee /dev/stderr | grep -q "Verification passed" &&
echo "simulation result: pass" ||
{ echo "simulation result: fail"; exit 1; }

//--- test/tb_flash_controller.sv
`timescale 1ns/1ns

module tb_flash_controller;

    import flash_pkg::*;

    localparam int timeout_cycles = 2000;

    logic clk;
    logic reset;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    erase_req_t erase_req;
    logic erase_done;
    qspi_pins_t pins;
    logic [3:0] flash_dq;

    logic flash_busy;
    int eb_count;
    int erase_count;
    int busy_reads;
    int oe_errors;
    logic [7:0] erase_block;

    logic [7:0] copy [4096];
    logic [255:0] erased;
    logic busy_at_ack;
    int check_errors = 0;
    int timeout_errors = 0;
    int done_pulses = 0;

    flash_controller #(
        .deselect_cycles(4)
    ) i_flash_controller (
        .clk(clk),
        .reset(reset),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp),
        .erase_req(erase_req),
        .erase_done(erase_done),
        .pins(pins),
        .flash_dq_in(flash_dq)
    );

    flash_model i_flash_model (
        .clk(clk),
        .pins(pins),
        .dq(flash_dq),
        .busy(flash_busy),
        .eb_count(eb_count),
        .erase_count(erase_count),
        .erase_block(erase_block),
        .busy_reads(busy_reads),
        .oe_errors(oe_errors)
    );

    always #4 clk = ~clk;

    always @(negedge clk) begin
        if (erase_done === 1'b1) begin
            done_pulses++;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] expected_byte(input logic [23:0] address);
        if (erased[address[23:16]]) begin
            return 8'hff;
        end
        return copy[address[11:0]];
    endfunction

    task automatic preload_memory();
        logic [31:0] seed;
        seed = 32'haf88_45c2;
        for (int i = 0; i < 4096; i++) begin
            seed = lcg_next(seed);
            copy[i] = seed[23:16];
            i_flash_model.mem[i] = seed[23:16];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            check_errors++;
            $display("CHECK FAILED: %s = %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_true(input logic condition, input string what);
        assert (condition === 1'b1) else begin
            check_errors++;
            $display("error: %s", what);
        end
    endtask

    // ========================================
    // bus transactions
    // ========================================

    task automatic read_half(input logic [23:0] address, output logic [15:0] data);
        int cycles;
        mem_req = '{request: 1'b1, address: address};
        data = 16'hxxxx;
        cycles = 0;
        @(negedge clk);
        while (mem_rsp.ack !== 1'b1 && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (mem_rsp.ack === 1'b1) begin
            data = mem_rsp.rdata;
            busy_at_ack = flash_busy;
        end else begin
            timeout_errors++;
            $display("timeout: read at address %h was never acknowledged", address);
        end
        // request stays up through the ack cycle.
        @(negedge clk);
        mem_req.request = 1'b0;
    endtask

    task automatic read_and_check(input logic [23:0] address);
        logic [15:0] data;
        logic [23:0] even;
        even = {address[23:1], 1'b0};
        read_half(address, data);
        check_value("mem_rsp.rdata", 32'(data),
                    32'({expected_byte(even), expected_byte(even + 24'd1)}));
    endtask

    task automatic erase_and_wait(input logic [7:0] block);
        int cycles;
        erase_req = '{pending: 1'b1, block: block};
        cycles = 0;
        @(negedge clk);
        while (erase_done !== 1'b1 && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (erase_done !== 1'b1) begin
            timeout_errors++;
            $display("timeout: erase of block %h never finished", block);
        end
        erase_req.pending = 1'b0;
        erased[block] = 1'b1;
    endtask

    // ========================================
    // directed tests
    // ========================================

    task automatic check_reset_state();
        check_value("pins.cs", 32'(pins.cs), 32'h1);
        check_value("pins.sck", 32'(pins.sck), 32'h0);
        check_value("pins.dq_oe_single", 32'(pins.dq_oe_single), 32'h0);
        check_value("pins.dq_oe_quad", 32'(pins.dq_oe_quad), 32'h0);
        check_value("mem_rsp.ack", 32'(mem_rsp.ack), 32'h0);
        check_value("erase_done", 32'(erase_done), 32'h0);
    endtask

    task automatic test_single_read();
        int eb_before;
        eb_before = eb_count;
        read_and_check(24'h00_0124);
        check_value("eb_count delta", 32'(eb_count - eb_before), 32'h1);
    endtask

    task automatic test_burst_read();
        int eb_before;
        eb_before = eb_count;
        for (int i = 0; i < 8; i++) begin
            read_and_check(24'h00_0200 + 24'(2 * i));
        end
        check_value("eb_count delta", 32'(eb_count - eb_before), 32'h1);
    endtask

    task automatic test_jump_read();
        int eb_before;
        eb_before = eb_count;
        read_and_check(24'h00_0a52);
        check_value("eb_count delta", 32'(eb_count - eb_before), 32'h1);
    endtask

    task automatic test_erase();
        int erases_before;
        int pulses_before;
        erases_before = erase_count;
        pulses_before = done_pulses;
        erase_and_wait(8'h01);
        read_and_check(24'h01_0040);
        check_value("erase_count delta", 32'(erase_count - erases_before), 32'h1);
        check_value("erase_block", 32'(erase_block), 32'h01);
        check_value("busy_reads", 32'(busy_reads), 32'h5);
        check_value("erase_done pulses", 32'(done_pulses - pulses_before), 32'h1);
        check_true(!busy_at_ack, "read after erase was acknowledged while the flash was busy");
    endtask

    task automatic test_erase_during_burst();
        int eb_before;
        int erases_before;
        int pulses_before;
        read_and_check(24'h00_0300);
        read_and_check(24'h00_0302);
        erases_before = erase_count;
        pulses_before = done_pulses;
        // burst is still open here.
        erase_and_wait(8'h02);
        eb_before = eb_count;
        read_and_check(24'h00_0304);
        read_and_check(24'h03_0010);
        read_and_check(24'h02_0010);
        check_value("erase_count delta", 32'(erase_count - erases_before), 32'h1);
        check_value("erase_block", 32'(erase_block), 32'h02);
        check_value("erase_done pulses", 32'(done_pulses - pulses_before), 32'h1);
        check_value("eb_count delta", 32'(eb_count - eb_before), 32'h3);
        check_true(!busy_at_ack, "read was acknowledged while the flash was busy");
    endtask

    // output enables as seen by the flash on every clock.
    task automatic check_output_enables();
        check_value("pins.dq_oe errors", 32'(oe_errors), 32'h0);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        mem_req = '0;
        erase_req = '0;
        erased = '0;
        busy_at_ack = 1'b0;
        preload_memory();
        repeat (2) @(negedge clk);
        reset = 1'b0;
        check_reset_state();
        test_single_read();
        test_burst_read();
        test_jump_read();
        test_erase();
        test_erase_during_burst();
        check_output_enables();
        $display("errors: %0d failed checks, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- test/flash_model.sv
`timescale 1ns/1ns

module flash_model #(
    parameter int busy_polls = 5
) (
    input logic clk,
    input flash_pkg::qspi_pins_t pins,
    output logic [3:0] dq,
    output logic busy,
    output int eb_count,
    output int erase_count,
    output logic [7:0] erase_block,
    output int busy_reads,
    output int oe_errors
);

    import flash_pkg::*;

    // 4 KB window, repeated in every 64 KB block.
    logic [7:0] mem [4096];
    logic [255:0] erased;
    logic wel;
    logic prev_sck;
    logic prev_cs;
    int clocks;
    logic [7:0] opcode;
    logic [23:0] address;

    initial begin
        dq = 4'h0;
        busy = 1'b0;
        eb_count = 0;
        erase_count = 0;
        erase_block = 8'h00;
        busy_reads = 0;
        oe_errors = 0;
        erased = '0;
        wel = 1'b0;
        prev_sck = 1'b0;
        prev_cs = 1'b1;
        clocks = 0;
        opcode = 8'h00;
        address = 24'h0;
    end

    function automatic logic [7:0] read_byte(input logic [23:0] byte_address);
        if (erased[byte_address[23:16]]) begin
            return 8'hff;
        end
        return mem[byte_address[11:0]];
    endfunction

    // ========================================
    // serial decode
    // ========================================

    task automatic clock_in();
        clocks = clocks + 1;
        if (clocks <= 8) begin
            if (!pins.dq_oe_single) begin
                oe_errors = oe_errors + 1;
            end
            opcode = {opcode[6:0], pins.dq_out[0]};
            if (clocks == 8 && opcode == cmd_fast_read_quad_io) begin
                eb_count = eb_count + 1;
            end
        end else if (opcode == cmd_block_erase_64kb && clocks <= 32) begin
            if (!pins.dq_oe_single) begin
                oe_errors = oe_errors + 1;
            end
            address = {address[22:0], pins.dq_out[0]};
        end else if (opcode == cmd_fast_read_quad_io && clocks <= 14) begin
            if (!pins.dq_oe_quad) begin
                oe_errors = oe_errors + 1;
            end
            address = {address[19:0], pins.dq_out};
        end
        // the flash owns the quad lines once data starts.
        if (opcode == cmd_fast_read_quad_io && clocks > 20 && pins.dq_oe_quad) begin
            oe_errors = oe_errors + 1;
        end
    endtask

    // output changes on the falling sck edge.
    task automatic drive_out();
        logic [7:0] status;
        logic [2:0] bit_pos;
        logic [7:0] data;
        int index;
        if (opcode == cmd_read_status_1 && clocks >= 8) begin
            status = 8'h00;
            status[status_busy_bit] = busy;
            status[1] = wel;
            bit_pos = 3'(clocks - 8);
            dq <= {2'b00, status[3'd7 - bit_pos], 1'b0};
        end else if (opcode == cmd_fast_read_quad_io && clocks >= 20) begin
            // opcode, six address, two mode and four dummy clocks.
            index = clocks - 20;
            data = read_byte(address + 24'(index / 2));
            dq <= index[0] ? data[3:0] : data[7:4];
        end
    endtask

    task automatic end_transaction();
        if (opcode == cmd_write_enable && clocks == 8) begin
            wel = 1'b1;
        end
        if (opcode == cmd_block_erase_64kb && clocks == 32 && wel) begin
            erased[address[23:16]] = 1'b1;
            erase_block = address[23:16];
            erase_count = erase_count + 1;
            busy = 1'b1;
            busy_reads = 0;
            wel = 1'b0;
        end
        if (opcode == cmd_read_status_1 && clocks >= 16 && busy) begin
            busy_reads = busy_reads + 1;
            if (busy_reads == busy_polls) begin
                busy = 1'b0;
            end
        end
        clocks = 0;
        opcode = 8'h00;
    endtask

    always @(posedge clk) begin
        if (prev_cs == 1'b0 && pins.cs == 1'b1) begin
            end_transaction();
        end else if (pins.cs == 1'b0) begin
            if (pins.sck && !prev_sck) begin
                clock_in();
            end else if (!pins.sck && prev_sck) begin
                drive_out();
            end
        end
        prev_sck = pins.sck;
        prev_cs = pins.cs;
    end

endmodule

//--- rtl/flash_controller.sv
`timescale 1ns/1ns

module flash_controller #(
    parameter int unsigned deselect_cycles = 4
) (
    input logic clk,
    input logic reset,
    input flash_pkg::mem_req_t mem_req,
    output flash_pkg::mem_rsp_t mem_rsp,
    input flash_pkg::erase_req_t erase_req,
    output logic erase_done,
    output flash_pkg::qspi_pins_t pins,
    input logic [3:0] flash_dq_in
);

    import flash_pkg::*;

    phy_cmd_t phy_cmd;
    phy_rsp_t phy_rsp;

    // ========================================
    // command FSM
    // ========================================

    flash_sequencer #(
        .deselect_cycles(deselect_cycles)
    ) i_flash_sequencer (
        .clk(clk),
        .reset(reset),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp),
        .erase_req(erase_req),
        .erase_done(erase_done),
        .phy_cmd(phy_cmd),
        .phy_rsp(phy_rsp)
    );

    // ========================================
    // byte shifter on the QSPI pins
    // ========================================

    qspi_phy i_qspi_phy (
        .clk(clk),
        .reset(reset),
        .cmd(phy_cmd),
        .rsp(phy_rsp),
        .pins(pins),
        .dq_in(flash_dq_in)
    );

endmodule

//--- rtl/flash_sequencer.sv
`timescale 1ns/1ns

module flash_sequencer #(
    parameter int unsigned deselect_cycles = 4
) (
    input logic clk,
    input logic reset,
    input flash_pkg::mem_req_t mem_req,
    output flash_pkg::mem_rsp_t mem_rsp,
    input flash_pkg::erase_req_t erase_req,
    output logic erase_done,
    output flash_pkg::phy_cmd_t phy_cmd,
    input flash_pkg::phy_rsp_t phy_rsp
);

    import flash_pkg::*;

    localparam logic [7:0] deselect_wdata = 8'(deselect_cycles);

    seq_state_e state;
    logic [2:0] counter;
    logic second_byte;
    logic [addr_width-1:0] current_address;

    logic cmd_start;
    logic cmd_finish;
    logic cmd_oe;
    logic cmd_quad;
    logic [7:0] cmd_wdata;

    logic ack;
    logic [15:0] rdata_word;

    logic issue;
    logic next_match;

    // a new strobe only when the PHY is idle and none is in flight.
    assign issue = !phy_rsp.busy && !cmd_start && !cmd_finish;
    assign next_match = mem_req.address[addr_width-1:1] == current_address[addr_width-1:1];

    assign phy_cmd = '{start: cmd_start, finish: cmd_finish, output_enable: cmd_oe,
                       quad_enable: cmd_quad, wdata: cmd_wdata};
    assign mem_rsp = '{ack: ack, rdata: rdata_word};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= state_idle;
            counter <= 3'd0;
            cmd_start <= 1'b0;
            cmd_finish <= 1'b0;
            cmd_oe <= 1'b0;
            cmd_quad <= 1'b0;
            ack <= 1'b0;
            erase_done <= 1'b0;
        end else begin
            cmd_start <= 1'b0;
            cmd_finish <= 1'b0;
            ack <= 1'b0;
            erase_done <= 1'b0;

            // count strobes as the PHY takes them.
            if (!phy_rsp.busy && (cmd_start || cmd_finish)) begin
                counter <= counter + 3'd1;
            end

            case (state)
                state_idle: begin
                    cmd_oe <= 1'b1;
                    cmd_quad <= 1'b0;
                    counter <= 3'd0;
                    if (erase_req.pending) begin
                        state <= state_write_enable;
                    end else if (mem_req.request) begin
                        current_address <= {mem_req.address[addr_width-1:1], 1'b0};
                        state <= state_read_start;
                    end
                end

                // ========================================
                // erase and status polling
                // ========================================

                state_write_enable: begin
                    if (counter == 3'd0 && issue) begin
                        cmd_start <= 1'b1;
                        cmd_wdata <= cmd_write_enable;
                    end else if (counter == 3'd1 && issue) begin
                        cmd_finish <= 1'b1;
                        cmd_wdata <= deselect_wdata;
                    end else if (counter == 3'd2 && issue) begin
                        counter <= 3'd0;
                        state <= state_erase;
                    end
                end

                state_erase: begin
                    if (issue) begin
                        case (counter)
                            3'd0: begin
                                cmd_start <= 1'b1;
                                cmd_wdata <= cmd_block_erase_64kb;
                            end
                            3'd1: begin
                                cmd_start <= 1'b1;
                                cmd_wdata <= erase_req.block;
                            end
                            3'd2, 3'd3: begin
                                cmd_start <= 1'b1;
                                cmd_wdata <= 8'h00;
                            end
                            3'd4: begin
                                cmd_finish <= 1'b1;
                                cmd_wdata <= deselect_wdata;
                            end
                            default: begin
                                erase_done <= 1'b1;
                                counter <= 3'd0;
                                state <= state_wait;
                            end
                        endcase
                    end
                end

                state_wait: begin
                    case (counter)
                        3'd0: begin
                            if (issue) begin
                                cmd_start <= 1'b1;
                                cmd_oe <= 1'b1;
                                cmd_wdata <= cmd_read_status_1;
                            end
                        end
                        3'd1: begin
                            if (issue) begin
                                cmd_start <= 1'b1;
                                cmd_oe <= 1'b0;
                            end
                        end
                        3'd2: begin
                            if (issue) begin
                                cmd_finish <= 1'b1;
                                cmd_wdata <= 8'h00;
                            end
                        end
                        default: begin
                            if (phy_rsp.valid) begin
                                if (phy_rsp.rdata[status_busy_bit]) begin
                                    counter <= 3'd0;
                                end else begin
                                    state <= state_idle;
                                end
                            end
                        end
                    endcase
                end

                // ========================================
                // quad fast read
                // ========================================

                state_read_start: begin
                    if (issue) begin
                        cmd_start <= 1'b1;
                        case (counter)
                            3'd0: cmd_wdata <= cmd_fast_read_quad_io;
                            3'd1: begin
                                cmd_quad <= 1'b1;
                                cmd_wdata <= current_address[23:16];
                            end
                            3'd2: cmd_wdata <= current_address[15:8];
                            3'd3: cmd_wdata <= current_address[7:0];
                            // mode byte, then two dummy bytes.
                            default: cmd_wdata <= 8'hff;
                        endcase
                        if (counter == 3'd7) begin
                            cmd_start <= 1'b0;
                            counter <= 3'd0;
                            second_byte <= 1'b0;
                            state <= state_read;
                        end
                    end
                end

                state_read: begin
                    if ((counter == 3'd0 || counter == 3'd1) && issue) begin
                        cmd_start <= 1'b1;
                        cmd_oe <= 1'b0;
                    end else if (counter == 3'd3) begin
                        if (erase_req.pending) begin
                            counter <= 3'd0;
                            state <= state_read_end;
                        end else if (mem_req.request && !ack) begin
                            counter <= 3'd0;
                            if (!next_match) begin
                                state <= state_read_end;
                            end
                        end
                    end
                    if (phy_rsp.valid) begin
                        second_byte <= ~second_byte;
                        if (second_byte) begin
                            ack <= 1'b1;
                            counter <= counter + 3'd1;
                            current_address <= current_address + 2;
                        end
                    end
                end

                state_read_end: begin
                    if (counter == 3'd0 && issue) begin
                        cmd_finish <= 1'b1;
                        cmd_wdata <= deselect_wdata;
                    end else if (counter == 3'd1 && issue) begin
                        state <= state_idle;
                    end
                end

                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

    // upper byte arrives first.
    always_ff @(posedge clk) begin
        if (phy_rsp.valid) begin
            rdata_word <= {rdata_word[7:0], phy_rsp.rdata};
        end
    end

    a_ack_has_request: assert property (
        @(posedge clk) disable iff (reset) ack |-> mem_req.request
    );

endmodule

//--- rtl/qspi_phy.sv
`timescale 1ns/1ns

module qspi_phy (
    input logic clk,
    input logic reset,
    input flash_pkg::phy_cmd_t cmd,
    output flash_pkg::phy_rsp_t rsp,
    output flash_pkg::qspi_pins_t pins,
    input logic [3:0] dq_in
);

    import flash_pkg::*;

    // pin state before the output register.
    logic sck_ff;
    logic cs_ff;
    logic oe_single_ff;
    logic oe_quad_ff;
    logic [3:0] dq_out_next;
    logic [3:0] dq_in_q;

    logic busy;
    logic valid;
    logic [7:0] rdata;

    logic running;
    logic deselect;
    logic receive;
    logic quad_mode;
    logic [2:0] bit_count;
    logic [7:0] deselect_count;
    logic [7:0] shift_out;
    logic [2:0] sample_single;
    logic [2:0] sample_quad;
    logic [2:0] valid_pipe;

    assign dq_out_next = quad_mode ? shift_out[7:4] : {3'b000, shift_out[7]};

    assign rsp = '{busy: busy, valid: valid, rdata: rdata};

    // ========================================
    // pin registers
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            pins <= '{sck: 1'b0, cs: 1'b1, dq_oe_single: 1'b0, dq_oe_quad: 1'b0,
                      dq_out: 4'h0};
        end else begin
            pins <= '{sck: sck_ff, cs: cs_ff, dq_oe_single: oe_single_ff,
                      dq_oe_quad: oe_quad_ff, dq_out: dq_out_next};
        end
    end

    always_ff @(posedge clk) begin
        dq_in_q <= dq_in;
    end

    // ========================================
    // byte shifter and deselect timer
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            sck_ff <= 1'b0;
            cs_ff <= 1'b1;
            oe_single_ff <= 1'b0;
            oe_quad_ff <= 1'b0;
            busy <= 1'b0;
            running <= 1'b0;
            deselect <= 1'b0;
            sample_single <= 3'b000;
            sample_quad <= 3'b000;
            valid_pipe <= 3'b000;
        end else begin
            sample_single <= {sample_single[1:0], 1'b0};
            sample_quad <= {sample_quad[1:0], 1'b0};
            valid_pipe <= {valid_pipe[1:0], 1'b0};

            if (running) begin
                sck_ff <= ~sck_ff;
                if (!sck_ff) begin
                    // rising edge goes out, sample it later.
                    if (bit_count == 3'd0) begin
                        busy <= 1'b0;
                        valid_pipe[0] <= receive;
                    end
                    if (quad_mode) begin
                        sample_quad[0] <= 1'b1;
                    end else begin
                        sample_single[0] <= 1'b1;
                    end
                end else begin
                    bit_count <= bit_count - 3'd1;
                    if (bit_count == 3'd0) begin
                        running <= 1'b0;
                    end
                    if (quad_mode) begin
                        shift_out <= {shift_out[3:0], 4'h0};
                    end else begin
                        shift_out <= {shift_out[6:0], 1'b0};
                    end
                end
            end

            if (deselect) begin
                if (deselect_count == 8'd0) begin
                    busy <= 1'b0;
                    deselect <= 1'b0;
                end else begin
                    deselect_count <= deselect_count - 8'd1;
                end
            end

            if (!busy && cmd.start) begin
                sck_ff <= 1'b0;
                cs_ff <= 1'b0;
                // line 0 stays driven in single mode.
                oe_single_ff <= !cmd.quad_enable || cmd.output_enable;
                oe_quad_ff <= cmd.quad_enable && cmd.output_enable;
                busy <= 1'b1;
                running <= 1'b1;
                receive <= !cmd.output_enable;
                quad_mode <= cmd.quad_enable;
                bit_count <= cmd.quad_enable ? 3'd1 : 3'd7;
                shift_out <= cmd.wdata;
            end else if (!busy && cmd.finish) begin
                cs_ff <= 1'b1;
                busy <= 1'b1;
                deselect <= 1'b1;
                deselect_count <= cmd.wdata;
            end
        end
    end

    // ========================================
    // receive path
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= valid_pipe[2];
        end
    end

    // flash drives its single-line output on dq1.
    always_ff @(posedge clk) begin
        if (sample_single[2]) begin
            rdata <= {rdata[6:0], dq_in_q[1]};
        end else if (sample_quad[2]) begin
            rdata <= {rdata[3:0], dq_in_q};
        end
    end

    a_single_strobe: assert property (
        @(posedge clk) disable iff (reset) !(cmd.start && cmd.finish)
    );

    a_no_strobe_while_busy: assert property (
        @(posedge clk) disable iff (reset) (cmd.start || cmd.finish) |-> !busy
    );

endmodule

//--- rtl/flash_pkg.sv
package flash_pkg;

    localparam int addr_width = 24;
    localparam int status_busy_bit = 0;

    // serial NOR opcodes in use.
    typedef enum logic [7:0] {
        cmd_read_status_1     = 8'h05,
        cmd_write_enable      = 8'h06,
        cmd_block_erase_64kb  = 8'hd8,
        cmd_fast_read_quad_io = 8'heb
    } flash_cmd_e;

    typedef enum logic [3:0] {
        state_idle,
        state_write_enable,
        state_erase,
        state_wait,
        state_read_start,
        state_read,
        state_read_end
    } seq_state_e;

    // ========================================
    // bus and link structs
    // ========================================

    // bit 0 of the address is ignored.
    typedef struct packed {
        logic request;
        logic [addr_width-1:0] address;
    } mem_req_t;

    typedef struct packed {
        logic ack;
        logic [15:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic pending;
        logic [7:0] block;
    } erase_req_t;

    typedef struct packed {
        logic start;
        logic finish;
        logic output_enable;
        logic quad_enable;
        logic [7:0] wdata;
    } phy_cmd_t;

    typedef struct packed {
        logic busy;
        logic valid;
        logic [7:0] rdata;
    } phy_rsp_t;

    typedef struct packed {
        logic sck;
        logic cs;
        logic dq_oe_single;
        logic dq_oe_quad;
        logic [3:0] dq_out;
    } qspi_pins_t;

endpackage
